// ==== all.f ====
+incdir+src
src/conv_data_pkg.sv
src/conv_ctrl_pkg.sv
src/tap_serializer.sv
src/tap_sequencer.sv
src/signed_mul_pipe.sv
src/conv_accum_requant.sv
src/conv_window_top.sv
dv/conv_window_checker.sv
dv/conv_window_tb.sv

// ==== dv/conv_window_tb.sv ====
//////////////////////////////////////////////////
// testbench for the 3x3 window datapath
// expected results come from a dot product model
// starts are marked accepted or ignored by the
// 10-cycle spacing, the checker does the compare
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "conv_config.svh"

module conv_window_tb;
  import conv_data_pkg::*;

  localparam int N_WINDOWS      = 223;                   // accepted windows of all tests
  localparam int TIMEOUT_CYCLES = 20 * N_WINDOWS + 100;

  logic         clk;
  logic         rstn;
  logic         start;
  window_t      feat_win;
  window_t      weight_win;
  tap_t         bias;
  logic         busy;
  logic         result_valid;
  conv_result_t result;
  logic         exp_push;
  conv_result_t exp_res;
  int           errors;
  int           pending;
  int           checked;
  int           tests_passed = 0;
  int           tests_failed = 0;
  int           cycles = 0;
  tap_t         corners [3];

  conv_window_top u_dut (
    .clk          (clk),
    .rstn         (rstn),
    .start        (start),
    .feat_win     (feat_win),
    .weight_win   (weight_win),
    .bias         (bias),
    .busy         (busy),
    .result_valid (result_valid),
    .result       (result)
  );

  conv_window_checker u_chk (
    .clk          (clk),
    .rstn         (rstn),
    .start        (start),
    .busy         (busy),
    .result_valid (result_valid),
    .result       (result),
    .exp_push     (exp_push),
    .exp_res      (exp_res),
    .errors       (errors),
    .pending      (pending),
    .checked      (checked)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // reference model and stimulus helpers
  //////////////////////////////////////////////////
  function automatic conv_result_t expected_result(input window_t f, input window_t w,
                                                   input tap_t b);
    int           sum;
    tap_t         ft;
    tap_t         wt;
    conv_result_t r;
    sum = 0;
    for (int i = 0; i < `CONV_TAPS; i++) begin
      ft  = f[i];
      wt  = w[i];
      sum = sum + int'(ft) * int'(wt);
    end
    sum   = sum + int'(b) * (1 << `CONV_BIAS_SHIFT);   // bias times 64
    r.acc = acc_t'(sum);
    if (sum < 0) begin
      r.q = 8'd0;
    end else if (sum >= (1 << (`CONV_BIAS_SHIFT + 7))) begin
      r.q = 8'd127;                                     // above the 7-bit field
    end else begin
      r.q = 8'(sum >> `CONV_BIAS_SHIFT);
    end
    return r;
  endfunction

  function automatic window_t fill_window(input tap_t v);
    window_t w;
    for (int i = 0; i < `CONV_TAPS; i++) begin
      w[i] = v;
    end
    return w;
  endfunction

  function automatic tap_t random_tap();
    logic [31:0] r;
    r = $urandom;
    return r[7:0];
  endfunction

  function automatic window_t random_window();
    window_t w;
    for (int i = 0; i < `CONV_TAPS; i++) begin
      w[i] = random_tap();
    end
    return w;
  endfunction

  // one start cycle, accept tells the checker whether a result is due
  task automatic issue(input window_t f, input window_t w, input tap_t b, input logic accept);
    @(posedge clk);
    start      <= 1'b1;
    feat_win   <= f;
    weight_win <= w;
    bias       <= b;
    exp_push   <= accept;
    exp_res    <= expected_result(f, w, b);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      start    <= 1'b0;
      exp_push <= 1'b0;
    end
  endtask

  task automatic send_window(input window_t f, input window_t w, input tap_t b, input int gap);
    issue(f, w, b, 1'b1);
    idle_cycles(gap - 1);
  endtask

  task automatic finish_test(input int num, input string name, input int err_base,
                             input int res_base);
    while (pending != 0) begin
      idle_cycles(1);
    end
    idle_cycles(12);   // room for a stray late result
    if (errors == err_base) begin
      tests_passed++;
      $display("test %0d %s: ok, %0d results", num, name, checked - res_base);
    end else begin
      tests_failed++;
      $display("test %0d %s: FAILED, %0d errors", num, name, errors - err_base);
    end
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////
  initial begin : main
    int          err_base;
    int          res_base;
    window_t     f;
    window_t     w;
    rstn       = 1'b0;
    start      = 1'b0;
    feat_win   = '0;
    weight_win = '0;
    bias       = '0;
    exp_push   = 1'b0;
    exp_res    = '0;
    corners[0] = 8'sh80;   // -128
    corners[1] = 8'shff;   // -1
    corners[2] = 8'sh7f;   // 127
    void'($urandom(32'h8f27));
    repeat (3) @(posedge clk);
    rstn <= 1'b1;

    err_base = errors;
    res_base = checked;
    for (int i = 0; i < `CONV_TAPS; i++) begin
      f[i] = tap_t'(i + 1);
      w[i] = tap_t'(9 - i);
    end
    send_window(f, w, 8'sd3, 10);
    finish_test(1, "reset and single window", err_base, res_base);

    // every sign combination at full magnitude
    err_base = errors;
    res_base = checked;
    for (int k = 0; k < 9; k++) begin
      send_window(fill_window(corners[k % 3]), fill_window(corners[k / 3]),
                  corners[(k + 1) % 3], 10);
    end
    finish_test(2, "signed corners", err_base, res_base);

    err_base = errors;
    res_base = checked;
    send_window(fill_window(8'sd10), fill_window(-8'sd10), 8'sd0, 10);   // -900, q 0
    send_window(fill_window(8'sd100), fill_window(8'sd100), 8'sd0, 10);  // saturates
    send_window(fill_window(8'sd5), fill_window(8'sd20), 8'sd2, 10);     // 1028, q 16
    send_window(fill_window(8'sd0), fill_window(8'sd0), 8'sd127, 10);    // 8128, q 127
    send_window(fill_window(8'sd0), fill_window(8'sd0), -8'sd1, 10);     // -64, q 0
    finish_test(3, "requantization", err_base, res_base);

    err_base = errors;
    res_base = checked;
    repeat (6) begin
      send_window(random_window(), random_window(), random_tap(), 10);
    end
    finish_test(4, "back-to-back windows", err_base, res_base);

    // ignored starts in cycle 4 and in cycle 9, the last busy cycle
    err_base = errors;
    res_base = checked;
    issue(random_window(), random_window(), random_tap(), 1'b1);
    idle_cycles(3);
    issue(random_window(), random_window(), random_tap(), 1'b0);
    idle_cycles(4);
    issue(random_window(), random_window(), random_tap(), 1'b0);
    issue(random_window(), random_window(), random_tap(), 1'b1);
    idle_cycles(9);
    finish_test(5, "start while busy", err_base, res_base);

    err_base = errors;
    res_base = checked;
    repeat (200) begin
      send_window(random_window(), random_window(), random_tap(), 10 + int'($urandom % 6));
    end
    finish_test(6, "random windows", err_base, res_base);

    $display("tests passed %0d, failed %0d, results %0d, errors %0d",
             tests_passed, tests_failed, checked, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // run limit
  initial begin
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== dv/conv_window_checker.sv ====
//////////////////////////////////////////////////
// watches the DUT ports and compares results
// expected values arrive with exp_push in the
// start cycle, in start order
// every result must come LATENCY cycles after
// its start
//////////////////////////////////////////////////
`timescale 1ns/1ps

module conv_window_checker #(
  parameter int LATENCY = 18
) (
  input  logic                         clk,
  input  logic                         rstn,
  input  logic                         start,
  input  logic                         busy,
  input  logic                         result_valid,
  input  conv_data_pkg::conv_result_t  result,
  input  logic                         exp_push,
  input  conv_data_pkg::conv_result_t  exp_res,
  output int                           errors,
  output int                           pending,
  output int                           checked
);
  import conv_data_pkg::*;

  conv_result_t exp_q [$];     // oldest window first
  int           start_q [$];   // start cycle of each window
  int           cycle = 0;
  int           n_err;
  int           start_c;
  conv_result_t exp_r;
  logic         rstn_d = 1'b0;

  always @(posedge clk) begin
    n_err = 0;
    cycle = cycle + 1;

    // first cycle out of reset
    if (rstn && !rstn_d && (busy !== 1'b0 || result_valid !== 1'b0)) begin
      $display("reset: busy or result_valid not low after reset (cycle %0d)", cycle);
      n_err++;
    end

    if (rstn) begin
      if (start && exp_push && busy) begin
        $display("start at cycle %0d should be accepted but busy is high", cycle);
        n_err++;
      end
      if (start && !exp_push && !busy) begin
        $display("start at cycle %0d should be ignored but busy is low", cycle);
        n_err++;
      end

      if (exp_push) begin
        exp_q.push_back(exp_res);
        start_q.push_back(cycle);
      end

      if (result_valid) begin
        if (exp_q.size() == 0) begin
          $display("result_valid at cycle %0d with no window outstanding", cycle);
          n_err++;
        end else begin
          exp_r   = exp_q.pop_front();
          start_c = start_q.pop_front();
          if (cycle - start_c != LATENCY) begin
            $display("result came %0d cycles after start, not %0d (cycle %0d)",
                     cycle - start_c, LATENCY, cycle);
            n_err++;
          end
          if (result.acc !== exp_r.acc) begin
            $display("MISMATCH result.acc: got 0x%07h expected 0x%07h (cycle %0d)",
                     result.acc, exp_r.acc, cycle);
            n_err++;
          end
          if (result.q !== exp_r.q) begin
            $display("MISMATCH result.q: got 0x%02h expected 0x%02h (cycle %0d)",
                     result.q, exp_r.q, cycle);
            n_err++;
          end
          checked <= checked + 1;
        end
      end
    end

    rstn_d = rstn;
    errors  <= errors + n_err;
    pending <= exp_q.size();
  end

endmodule

// ==== src/conv_window_top.sv ====
//////////////////////////////////////////////////
// one 3x3 window as a serial dot product
// windows and bias are sampled with start
// result_valid comes 18 cycles after start, new
// starts are taken every 10 cycles at most
//////////////////////////////////////////////////
`timescale 1ns/1ps

module conv_window_top (
  input  logic                         clk,
  input  logic                         rstn,
  input  logic                         start,
  input  conv_data_pkg::window_t       feat_win,
  input  conv_data_pkg::window_t       weight_win,
  input  conv_data_pkg::tap_t          bias,
  output logic                         busy,
  output logic                         result_valid,
  output conv_data_pkg::conv_result_t  result
);
  import conv_data_pkg::*;
  import conv_ctrl_pkg::*;

  logic      load;
  logic      shift;
  tap_side_t seq_side;
  tap_t      feat_tap;
  tap_t      weight_tap;
  product_t  product;
  tap_side_t mul_side;

  tap_sequencer u_seq (
    .clk   (clk),
    .rstn  (rstn),
    .start (start),
    .bias  (bias),
    .busy  (busy),
    .load  (load),
    .shift (shift),
    .side  (seq_side)
  );

  tap_serializer #(.tap_type(tap_t)) u_feat_ser (
    .clk   (clk),
    .rstn  (rstn),
    .load  (load),
    .shift (shift),
    .win   (feat_win),
    .head  (feat_tap)
  );

  tap_serializer #(.tap_type(tap_t)) u_weight_ser (
    .clk   (clk),
    .rstn  (rstn),
    .load  (load),
    .shift (shift),
    .win   (weight_win),
    .head  (weight_tap)
  );

  signed_mul_pipe #(.side_type(tap_side_t)) u_mul (
    .clk      (clk),
    .rstn     (rstn),
    .a        (feat_tap),
    .b        (weight_tap),
    .side_in  (seq_side),
    .product  (product),
    .side_out (mul_side)
  );

  conv_accum_requant u_acc (
    .clk          (clk),
    .rstn         (rstn),
    .product      (product),
    .side         (mul_side),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

// ==== src/conv_accum_requant.sv ====
//////////////////////////////////////////////////
// window accumulator with bias and requantization
// q is relu then saturation to 7 bits, taken from
// acc bits 12..6. result_valid pulses one cycle
// after the last product and is not held
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "conv_config.svh"

module conv_accum_requant (
  input  logic                         clk,
  input  logic                         rstn,
  input  conv_data_pkg::product_t      product,
  input  conv_ctrl_pkg::tap_side_t     side,
  output logic                         result_valid,
  output conv_data_pkg::conv_result_t  result
);
  import conv_data_pkg::*;

  localparam int Q_LO   = `CONV_BIAS_SHIFT;
  localparam int Q_HI   = Q_LO + 6;          // 7-bit output field
  localparam int SAT_HI = `CONV_ACC_W - 2;   // below the sign bit

  acc_t   sum_q;
  acc_t   sum_next;
  acc_t   biased;
  quant_t q_next;

  // first product of a window restarts the sum
  assign sum_next = (side.first ? acc_t'(0) : sum_q) + acc_t'(product);
  assign biased   = sum_next + (acc_t'(side.bias) <<< `CONV_BIAS_SHIFT);

  always_comb begin
    if (biased[`CONV_ACC_W-1]) begin
      q_next = '0;                           // relu
    end else if (|biased[SAT_HI:Q_HI+1]) begin
      q_next = quant_t'(8'h7f);              // saturate
    end else begin
      q_next = quant_t'(biased[Q_HI:Q_LO]);
    end
  end

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (side.valid) begin
      sum_q <= sum_next;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= side.valid && side.last;
    end
  end

  always_ff @(posedge clk) begin
    if (side.valid && side.last) begin
      result.acc <= biased;
      result.q   <= q_next;
    end
  end

endmodule

// ==== src/signed_mul_pipe.sv ====
//////////////////////////////////////////////////
// 8-stage signed 8x8 multiplier
// magnitudes are multiplied, the sign is fixed up
// in the last stage. one pair per cycle, result
// and sideband 8 cycles after the pair enters
// stage widths assume 8-bit operands
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "conv_config.svh"

module signed_mul_pipe #(
  parameter type side_type = conv_ctrl_pkg::tap_side_t
) (
  input  logic                     clk,
  input  logic                     rstn,
  input  conv_data_pkg::tap_t      a,
  input  conv_data_pkg::tap_t      b,
  input  side_type                 side_in,
  output conv_data_pkg::product_t  product,
  output side_type                 side_out
);
  import conv_data_pkg::*;

  localparam int STAGES = `CONV_MUL_STAGES;

  logic [7:0]        a_mag;
  logic [7:0]        b_mag;
  logic              sign;
  logic [7:0]        pp [8];        // stage 1 partial products
  logic [5:0]        lo2 [4];       // stage 2 low sums with carry
  logic [2:0]        hi2_a [4];
  logic [3:0]        hi2_b [4];
  logic [9:0]        sum3 [4];      // stage 3
  logic [7:0]        lo4 [2];       // stage 4
  logic [2:0]        hi4_a [2];
  logic [4:0]        hi4_b [2];
  logic [11:0]       sum5 [2];      // stage 5
  logic [9:0]        lo6;           // stage 6
  logic [2:0]        hi6_a;
  logic [6:0]        hi6_b;
  logic [15:0]       mag7;          // stage 7 unsigned product
  logic [STAGES-2:0] sign_d;
  side_type          side_d [STAGES];

  assign a_mag = a[7] ? 8'(~a + 1'b1) : 8'(a);
  assign b_mag = b[7] ? 8'(~b + 1'b1) : 8'(b);
  assign sign  = a[7] ^ b[7];

  //////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    // stage 1: one row per multiplier bit
    for (int i = 0; i < 8; i++) begin
      pp[i] <= b_mag[i] ? a_mag : 8'h00;
    end

    // stage 2: pairs of rows, low parts first
    for (int k = 0; k < 4; k++) begin
      lo2[k]   <= pp[2*k][4:0] + {pp[2*k+1][3:0], 1'b0};
      hi2_a[k] <= pp[2*k][7:5];
      hi2_b[k] <= pp[2*k+1][7:4];
    end

    // stage 3: high parts with the carry
    for (int k = 0; k < 4; k++) begin
      sum3[k] <= {5'(hi2_a[k] + hi2_b[k] + lo2[k][5]), lo2[k][4:0]};
    end

    // stage 4: second sum is 2 bits up
    for (int j = 0; j < 2; j++) begin
      lo4[j]   <= sum3[2*j][6:0] + {sum3[2*j+1][4:0], 2'b00};
      hi4_a[j] <= sum3[2*j][9:7];
      hi4_b[j] <= sum3[2*j+1][9:5];
    end

    for (int j = 0; j < 2; j++) begin  // stage 5
      sum5[j] <= {5'(hi4_a[j] + hi4_b[j] + lo4[j][7]), lo4[j][6:0]};
    end

    // stage 6: second sum is 4 bits up
    lo6   <= sum5[0][8:0] + {sum5[1][4:0], 4'h0};
    hi6_a <= sum5[0][11:9];
    hi6_b <= sum5[1][11:5];

    mag7 <= {7'(hi6_a + hi6_b + lo6[9]), lo6[8:0]};  // stage 7

    // stage 8: sign fix
    if (sign_d[STAGES-2]) begin
      product <= product_t'(~mag7 + 1'b1);
    end else begin
      product <= product_t'(mag7);
    end

    sign_d <= {sign_d[STAGES-3:0], sign};  // lines up with stages 1..7
  end

  //////////////////////////////////////////////////
  // sideband delay
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int i = 0; i < STAGES; i++) begin
        side_d[i] <= '0;
      end
    end else begin
      side_d[0] <= side_in;
      for (int i = 1; i < STAGES; i++) begin
        side_d[i] <= side_d[i-1];
      end
    end
  end

  assign side_out = side_d[STAGES-1];

endmodule

// ==== src/tap_sequencer.sv ====
//////////////////////////////////////////////////
// start to tap-stream control
// a start while busy is ignored
// taps 0..8 go out in the 9 cycles after start,
// busy drops one cycle after the last tap
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "conv_config.svh"

module tap_sequencer (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      start,
  input  conv_data_pkg::tap_t       bias,
  output logic                      busy,
  output logic                      load,
  output logic                      shift,
  output conv_ctrl_pkg::tap_side_t  side
);
  import conv_ctrl_pkg::*;

  localparam tap_idx_t LAST_IDX = tap_idx_t'(`CONV_TAPS - 1);
  localparam tap_idx_t PRE_LAST = tap_idx_t'(`CONV_TAPS - 2);

  tap_idx_t  tap_cnt;   // tap now at the serializer heads
  tap_side_t side_q;

  assign load  = start && !busy;   // accepted start
  assign shift = busy;             // advance after every presented tap
  assign side  = side_q;

  //////////////////////////////////////////////////
  // tap counter and sideband
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      busy    <= 1'b0;
      tap_cnt <= '0;
      side_q  <= '0;
    end else if (load) begin
      busy         <= 1'b1;
      tap_cnt      <= '0;
      side_q.valid <= 1'b1;
      side_q.first <= 1'b1;
      side_q.last  <= 1'b0;
      side_q.bias  <= bias;          // held for the whole window
    end else if (busy) begin
      if (tap_cnt == LAST_IDX) begin
        // window done
        busy         <= 1'b0;
        side_q.valid <= 1'b0;
        side_q.last  <= 1'b0;
      end else begin
        tap_cnt      <= tap_cnt + 1'b1;
        side_q.first <= 1'b0;
        side_q.last  <= (tap_cnt == PRE_LAST);  // next tap is the last
      end
    end
  end

endmodule

// ==== src/tap_serializer.sv ====
//////////////////////////////////////////////////
// holds one window and presents one tap per shift
// load wins over shift in the same cycle
// after the last shift head reads zero
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "conv_config.svh"

module tap_serializer #(
  parameter type tap_type = conv_data_pkg::tap_t
) (
  input  logic                       clk,
  input  logic                       rstn,
  input  logic                       load,
  input  logic                       shift,
  input  tap_type [`CONV_TAPS-1:0]   win,
  output tap_type                    head
);

  tap_type [`CONV_TAPS-1:0] taps;   // taps[0] is the current tap

  always_ff @(posedge clk) begin
    if (!rstn) begin
      taps <= '0;
    end else if (load) begin
      taps <= win;
    end else if (shift) begin
      // move the next tap down, zero fills the top
      taps <= taps >> $bits(tap_type);
    end
  end

  assign head = taps[0];

endmodule

// ==== src/conv_ctrl_pkg.sv ====
//////////////////////////////////////////////////
// sideband that travels with each tap pair
// through the multiplier
//////////////////////////////////////////////////
`include "conv_config.svh"

package conv_ctrl_pkg;

  // tap position inside a window
  typedef logic [$clog2(`CONV_TAPS)-1:0] tap_idx_t;

  typedef struct packed {
    logic                valid;
    logic                first;  // first tap of a window
    logic                last;   // last tap of a window
    conv_data_pkg::tap_t bias;   // bias of the window
  } tap_side_t;

endpackage

// ==== src/conv_data_pkg.sv ====
//////////////////////////////////////////////////
// data formats of the window datapath
// taps are signed two's complement values
// tap 0 sits in the low byte of a window
//////////////////////////////////////////////////
`include "conv_config.svh"

package conv_data_pkg;

  // one feature, weight or bias value
  typedef logic signed [`CONV_DATA_W-1:0] tap_t;

  typedef tap_t [`CONV_TAPS-1:0] window_t;          // tap 0 is sent first

  typedef logic signed [2*`CONV_DATA_W-1:0] product_t;

  typedef logic signed [`CONV_ACC_W-1:0] acc_t;

  // relu output, msb always zero
  typedef logic [`CONV_DATA_W-1:0] quant_t;

  typedef struct packed {
    acc_t   acc;  // biased sum
    quant_t q;    // requantized value
  } conv_result_t;

endpackage

// ==== src/conv_config.svh ====
//////////////////////////////////////////////////
// sizes shared by the packages and the RTL
// the multiplier stage widths are fixed for 8-bit
// operands. CONV_DATA_W and CONV_MUL_STAGES cannot
// be changed on their own
//////////////////////////////////////////////////
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

// taps in one 3x3 window
`define CONV_TAPS 9

// feature, weight and bias width
`define CONV_DATA_W 8

`define CONV_ACC_W 28       // accumulator and raw result

// bias is scaled by 2^6 before the add, also low bit of q
`define CONV_BIAS_SHIFT 6

`define CONV_MUL_STAGES 8   // register stages in the multiplier

`endif
